/* hw/ram_arb_pkg.sv */
`default_nettype none

package ram_arb_pkg;

  // Memory geometry
  localparam int ADDR_W = 10;  // Word address bits
  localparam int DATA_W = 16;  // Word width
  localparam int ROW_W  = 6;   // Refresh row counter bits

  // Timing
  localparam int REFRESH_INTERVAL = 64; // Clocks between refresh requests
  localparam int CYCLE_LEN        = 3;  // Clocks per access or refresh, start to done

  // Counter widths derived from the timing above
  localparam int CYC_CNT_W = $clog2(CYCLE_LEN);        // Sequencer step counter
  localparam int REF_CNT_W = $clog2(REFRESH_INTERVAL); // Refresh interval counter

  // Current owner of the memory
  typedef enum logic [1:0] {
    GNT_NONE    = 2'd0,
    GNT_REFRESH = 2'd1,
    GNT_CPU     = 2'd2,
    GNT_BUS     = 2'd3
  } grant_t;

endpackage

`default_nettype wire

/* hw/wb_port.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_port
  import ram_arb_pkg::*;
(
  input  logic              CK,
  input  logic              arst_n,
  // Wishbone classic slave side
  input  logic              cyc,
  input  logic              stb,
  input  logic              we,
  input  logic              lock,
  input  logic [ADDR_W-1:0] adr,
  input  logic [DATA_W-1:0] dat_w,
  output logic [DATA_W-1:0] dat_r,
  output logic              ack,
  // Towards the arbiter
  output logic              req,
  output logic              lock_o,
  // From arbiter and memory
  input  logic              mine,     // Grant names this port
  input  logic              done,
  input  logic [DATA_W-1:0] rd_data
);

  logic take; // Memory cycle finished for us

  assign take = done & mine;

  // Request while the bus cycle is open and not yet acked
  assign req    = cyc & stb & ~ack;
  assign lock_o = lock; // Semaphore hold goes straight to the arbiter

  // Ack one cycle after done
  always_ff @(posedge CK or negedge arst_n) begin
    if (!arst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= take; // Single pulse as done is one cycle
    end
  end

  // Read data captured with the ack
  always_ff @(posedge CK) begin
    if (take) begin
      dat_r <= rd_data;
    end
  end

  // Ack only answers an open bus cycle that held the grant
  a_ack_after_grant: assert property (
    @(posedge CK) disable iff (!arst_n)
    ack |-> $past(mine && cyc && stb)
  ) else $error("wb_port: ack without grant");

  // Master keeps address and data steady up to and including ack
  a_master_stable: assert property (
    @(posedge CK) disable iff (!arst_n)
    req |=> (cyc && stb && $stable({we, adr, dat_w}))
  ) else $error("wb_port: master changed inputs before ack");

endmodule

`default_nettype wire

/* hw/refresh_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module refresh_timer
  import ram_arb_pkg::*;
(
  input  logic CK,
  input  logic arst_n,
  input  logic served,  // Refresh start seen by the timer
  output logic ref_req
);

  logic [REF_CNT_W-1:0] cnt; // Clocks left to the next request

  always_ff @(posedge CK or negedge arst_n) begin
    if (!arst_n) begin
      cnt     <= REF_CNT_W'(REFRESH_INTERVAL - 1);
      ref_req <= 1'b0;
    end else if (served) begin
      cnt     <= REF_CNT_W'(REFRESH_INTERVAL - 1); // Restart interval
      ref_req <= 1'b0;
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end else begin
      ref_req <= 1'b1; // Parked at zero, hold until served
    end
  end

  // Grant side may only serve an open request
  a_served_with_req: assert property (
    @(posedge CK) disable iff (!arst_n)
    served |-> ref_req
  ) else $error("refresh_timer: served without request");

endmodule

`default_nettype wire

/* hw/ram_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter
  import ram_arb_pkg::*;
(
  input  logic   CK,
  input  logic   arst_n,
  input  logic   ref_req,
  input  logic   cpu_req,
  input  logic   bus_req,
  input  logic   cpu_lock,
  input  logic   bus_lock,
  input  logic   done,     // Memory cycle finished
  output grant_t gnt,
  output logic   start     // One pulse per grant
);

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUSY = 2'd1,
    ST_GAP  = 2'd2
  } state_t;

  state_t state;
  grant_t nxt;         // Winner if a decision is taken now
  grant_t last_owner;  // Owner of the finished cycle
  logic   last_ref;    // Previous grant was refresh
  logic   lock_held;   // Last owner ended with lock up
  logic   first_dec;   // First idle cycle after the gap
  logic   cpu_keeps;   // CPU reclaims locked memory
  logic   bus_keeps;   // Bus reclaims locked memory

  // Lock only counts if the owner comes straight back
  assign cpu_keeps = first_dec & lock_held & (last_owner == GNT_CPU) & cpu_req;
  assign bus_keeps = first_dec & lock_held & (last_owner == GNT_BUS) & bus_req;

  // Priority order
  always_comb begin
    nxt = GNT_NONE;
    if (ref_req) begin
      nxt = GNT_REFRESH;            // Refresh beats everything, even a lock
    end else if (cpu_keeps) begin
      nxt = GNT_CPU;
    end else if (bus_keeps) begin
      nxt = GNT_BUS;
    end else if (last_ref && cpu_req) begin
      nxt = GNT_CPU;                // CPU gets the slot behind refresh
    end else if (bus_req) begin
      nxt = GNT_BUS;
    end else if (cpu_req) begin
      nxt = GNT_CPU;
    end
  end

  always_ff @(posedge CK or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_IDLE;
      gnt        <= GNT_NONE;
      start      <= 1'b0;
      last_owner <= GNT_NONE;
      last_ref   <= 1'b0;
      lock_held  <= 1'b0;
      first_dec  <= 1'b0;
    end else begin
      start <= 1'b0; // Pulse default
      case (state)
        ST_IDLE: begin
          first_dec <= 1'b0; // Lock window is one decision only
          if (nxt != GNT_NONE) begin
            gnt      <= nxt;
            start    <= 1'b1;
            last_ref <= (nxt == GNT_REFRESH);
            state    <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (done) begin
            last_owner <= gnt;
            // Remember whether the owner wants to keep the memory
            lock_held  <= ((gnt == GNT_CPU) & cpu_lock) | ((gnt == GNT_BUS) & bus_lock);
            gnt        <= GNT_NONE;
            state      <= ST_GAP;
          end
        end
        ST_GAP: begin
          first_dec <= 1'b1; // Next cycle is the first decision
          state     <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Owner does not change under a running memory cycle
  a_gnt_stable: assert property (
    @(posedge CK) disable iff (!arst_n)
    (state == ST_BUSY && !done) |=> $stable(gnt)
  ) else $error("ram_arbiter: grant changed while busy");

  a_start_from_idle: assert property (
    @(posedge CK) disable iff (!arst_n)
    start |-> ($past(state) == ST_IDLE)
  ) else $error("ram_arbiter: start outside idle");

endmodule

`default_nettype wire

/* hw/ram_cycle.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_cycle
  import ram_arb_pkg::*;
(
  input  logic              CK,
  input  logic              arst_n,
  input  logic              start,
  input  grant_t            gnt,
  input  logic [ADDR_W-1:0] adr,    // Already muxed by grant
  input  logic              we,
  input  logic [DATA_W-1:0] dat_w,
  output logic              done,
  output logic [DATA_W-1:0] rd_data,
  output logic              refresh_cmd,
  output logic [ROW_W-1:0]  refresh_row
);

  logic [DATA_W-1:0]    mem [2**ADDR_W]; // On-chip array
  logic                 active;          // Cycle in progress
  logic [CYC_CNT_W-1:0] cnt;             // Steps since start
  logic                 last_step;       // Next edge raises done
  logic                 access;          // Grant is a port, not refresh

  assign access    = (gnt == GNT_CPU) || (gnt == GNT_BUS);
  assign last_step = active && (cnt == CYC_CNT_W'(CYCLE_LEN - 2));

  // Sequencer, done lands CYCLE_LEN clocks after start
  always_ff @(posedge CK or negedge arst_n) begin
    if (!arst_n) begin
      active      <= 1'b0;
      cnt         <= '0;
      done        <= 1'b0;
      refresh_cmd <= 1'b0;
      refresh_row <= '0;
    end else begin
      done        <= 1'b0;
      refresh_cmd <= 1'b0;
      if (start) begin
        active <= 1'b1;
        cnt    <= '0;
      end else if (last_step) begin
        active      <= 1'b0;
        done        <= 1'b1;
        refresh_cmd <= (gnt == GNT_REFRESH); // Command rides on done
      end else if (active) begin
        cnt <= cnt + 1'b1;
      end
      if (refresh_cmd) begin
        refresh_row <= refresh_row + 1'b1; // Wraps at 2**ROW_W
      end
    end
  end

  // Array port, write on start, read just before done
  always_ff @(posedge CK) begin
    if (start && access && we) begin
      mem[adr] <= dat_w;
    end
    if (last_step && access) begin
      rd_data <= mem[adr];
    end
  end

endmodule

`default_nettype wire

/* hw/ram_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_subsys_top
  import ram_arb_pkg::*;
(
  input  logic              CK,
  input  logic              arst_n,
  // CPU port
  input  logic              cpu_cyc,
  input  logic              cpu_stb,
  input  logic              cpu_we,
  input  logic              cpu_lock,
  input  logic [ADDR_W-1:0] cpu_adr,
  input  logic [DATA_W-1:0] cpu_dat_w,
  output logic [DATA_W-1:0] cpu_dat_r,
  output logic              cpu_ack,
  // System bus port
  input  logic              bus_cyc,
  input  logic              bus_stb,
  input  logic              bus_we,
  input  logic              bus_lock,
  input  logic [ADDR_W-1:0] bus_adr,
  input  logic [DATA_W-1:0] bus_dat_w,
  output logic [DATA_W-1:0] bus_dat_r,
  output logic              bus_ack,
  // Refresh consumer
  output logic              refresh_cmd,
  output logic [ROW_W-1:0]  refresh_row
);

  logic              cpu_req, bus_req;
  logic              cpu_lock_arb, bus_lock_arb;
  logic              ref_req;
  grant_t            gnt;
  logic              start, done;
  logic [DATA_W-1:0] rd_data;
  logic              sel_bus;  // Bus owns the memory
  logic [ADDR_W-1:0] mem_adr;
  logic              mem_we;
  logic [DATA_W-1:0] mem_dat_w;

  // Master signals picked by the owner, CPU side for refresh is ignored
  assign sel_bus   = (gnt == GNT_BUS);
  assign mem_adr   = sel_bus ? bus_adr   : cpu_adr;
  assign mem_we    = sel_bus ? bus_we    : cpu_we;
  assign mem_dat_w = sel_bus ? bus_dat_w : cpu_dat_w;

  wb_port u_cpu_port (
    .CK(CK), .arst_n(arst_n),
    .cyc(cpu_cyc), .stb(cpu_stb), .we(cpu_we), .lock(cpu_lock),
    .adr(cpu_adr), .dat_w(cpu_dat_w), .dat_r(cpu_dat_r), .ack(cpu_ack),
    .req(cpu_req), .lock_o(cpu_lock_arb),
    .mine(gnt == GNT_CPU), .done(done), .rd_data(rd_data)
  );

  wb_port u_bus_port (
    .CK(CK), .arst_n(arst_n),
    .cyc(bus_cyc), .stb(bus_stb), .we(bus_we), .lock(bus_lock),
    .adr(bus_adr), .dat_w(bus_dat_w), .dat_r(bus_dat_r), .ack(bus_ack),
    .req(bus_req), .lock_o(bus_lock_arb),
    .mine(sel_bus), .done(done), .rd_data(rd_data)
  );

  // Timer request cleared by the refresh grant
  refresh_timer u_refresh (
    .CK(CK), .arst_n(arst_n),
    .served(start && (gnt == GNT_REFRESH)),
    .ref_req(ref_req)
  );

  ram_arbiter u_arbiter (
    .CK(CK), .arst_n(arst_n),
    .ref_req(ref_req), .cpu_req(cpu_req), .bus_req(bus_req),
    .cpu_lock(cpu_lock_arb), .bus_lock(bus_lock_arb),
    .done(done), .gnt(gnt), .start(start)
  );

  ram_cycle u_ram (
    .CK(CK), .arst_n(arst_n),
    .start(start), .gnt(gnt),
    .adr(mem_adr), .we(mem_we), .dat_w(mem_dat_w),
    .done(done), .rd_data(rd_data),
    .refresh_cmd(refresh_cmd), .refresh_row(refresh_row)
  );

endmodule

`default_nettype wire

/* testbench/tb_ram_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ram_subsys
  import ram_arb_pkg::*;
();

  localparam int TABLE_LEN       = 16;
  localparam int NUM_PASSES      = 40;  // Table repeats needed for refresh_row to wrap
  localparam int WATCHDOG_CYCLES = NUM_PASSES * TABLE_LEN * 40 + 4 * REFRESH_INTERVAL;
  localparam int MAX_REF_GAP     = REFRESH_INTERVAL + 20;

  typedef enum logic [1:0] {SEL_CPU, SEL_BUS, SEL_BOTH} sel_t;

  typedef struct packed {
    sel_t              sel;
    logic              we;
    logic              lock;  // Locked CPU read-write against a late bus read with SEL_BOTH
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;   // Mixed into the LCG word
  } entry_t;

  logic              CK, arst_n;
  logic              cpu_cyc, cpu_stb, cpu_we, cpu_lock, cpu_ack;
  logic              bus_cyc, bus_stb, bus_we, bus_lock, bus_ack;
  logic [ADDR_W-1:0] cpu_adr, bus_adr;
  logic [DATA_W-1:0] cpu_dat_w, cpu_dat_r, bus_dat_w, bus_dat_r;
  logic              refresh_cmd;
  logic [ROW_W-1:0]  refresh_row;

  entry_t            stim [TABLE_LEN];
  logic [DATA_W-1:0] ref_mem [2**ADDR_W];  // Expected memory contents
  logic [31:0]       lcg_state = 32'h7c2;
  grant_t            ack_log [$];           // Port of every ack in order
  logic              ref_log [$];           // Refresh seen since the previous ack
  logic              ref_pending = 1'b0;
  int                ref_count = 0;
  int                ref_gap = 0;           // Cycles since the last refresh_cmd
  logic [ROW_W-1:0]  exp_row = '0;

  ram_subsys_top u_dut (.*);

  initial CK = 1'b0;
  always #5 CK = ~CK;  // 10 ns period

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_row(input logic [ROW_W-1:0] got, input logic [ROW_W-1:0] exp,
                           input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_order(input grant_t got, input grant_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %s expected %s", $time, what, got.name(),
               exp.name());
      stop_run();
    end
  endtask

  task automatic drive_port(input grant_t port, input logic act, input logic we,
                            input logic lock, input logic [ADDR_W-1:0] adr,
                            input logic [DATA_W-1:0] dat);
    if (port == GNT_CPU) begin
      cpu_cyc = act;
      cpu_stb = act;
      cpu_we = we;
      cpu_lock = lock;
      cpu_adr = adr;
      cpu_dat_w = dat;
    end else begin
      bus_cyc = act;
      bus_stb = act;
      bus_we = we;
      bus_lock = lock;
      bus_adr = adr;
      bus_dat_w = dat;
    end
  endtask

  // One classic cycle from 1 ns after an edge to 1 ns after the edge ending ack
  task automatic wb_access(input grant_t port, input logic we, input logic lock,
                           input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
                           output logic [DATA_W-1:0] rdat);
    logic got;
    drive_port(port, 1'b1, we, lock, adr, dat);
    got = 1'b0;
    while (!got) begin
      @(posedge CK);
      #1;
      got = (port == GNT_CPU) ? cpu_ack : bus_ack;
    end
    rdat = (port == GNT_CPU) ? cpu_dat_r : bus_dat_r;
    @(posedge CK);  // Inputs held through the ack cycle
    #1;
    drive_port(port, 1'b0, 1'b0, 1'b0, adr, dat);
  endtask

  task automatic run_entry(input entry_t e);
    logic [31:0]       rnd;
    logic [DATA_W-1:0] d, old, rd_a, rd_b, rd_c;
    logic [ADDR_W-1:0] a2;
    grant_t            port, exp_first;
    int                base;
    rnd  = lcg_next();
    d    = rnd[31:16] ^ e.dat;
    a2   = e.adr ^ ADDR_W'(1);  // Bus word of a pair
    old  = ref_mem[e.adr];
    base = ack_log.size();
    @(posedge CK);
    #1;
    if (e.sel != SEL_BOTH) begin
      port = (e.sel == SEL_CPU) ? GNT_CPU : GNT_BUS;
      wb_access(port, e.we, e.lock, e.adr, d, rd_a);
      if (e.we) begin
        ref_mem[e.adr] = d;
      end else begin
        check_data(rd_a, old, "single read");
      end
    end else if (!e.lock) begin
      fork
        wb_access(GNT_CPU, e.we, 1'b0, e.adr, d, rd_a);
        wb_access(GNT_BUS, e.we, 1'b0, a2, ~d, rd_b);
      join
      if (e.we) begin
        ref_mem[e.adr] = d;
        ref_mem[a2] = ~d;
      end else begin
        check_data(rd_a, ref_mem[e.adr], "CPU read in pair");
        check_data(rd_b, ref_mem[a2], "bus read in pair");
      end
      // Bus wins unless refresh took the slot since the last ack
      exp_first = ref_log[base] ? GNT_CPU : GNT_BUS;
      check_order(ack_log[base], exp_first, "first ack of a simultaneous pair");
    end else begin
      fork
        begin
          wb_access(GNT_CPU, 1'b0, 1'b1, e.adr, '0, rd_a);  // Locked read
          wb_access(GNT_CPU, 1'b1, 1'b0, e.adr, d, rd_b);   // Write back with lock dropped
        end
        begin
          repeat (2) @(posedge CK);  // Bus arrives once CPU owns the memory
          #1;
          wb_access(GNT_BUS, 1'b0, 1'b0, e.adr, '0, rd_c);
        end
      join
      ref_mem[e.adr] = d;
      check_data(rd_a, old, "locked CPU read");
      check_order(ack_log[base], GNT_CPU, "first ack of a locked sequence");
      if (!ref_log[base + 1]) begin
        check_order(ack_log[base + 1], GNT_CPU, "locked CPU write ahead of waiting bus");
      end
      // CPU write goes first even behind a refresh, so the bus sees new data
      check_data(rd_c, d, "bus read behind lock");
    end
  endtask

  // Refresh and ack monitor at mid-cycle
  always @(negedge CK) begin
    if (arst_n) begin
      if (refresh_cmd) begin
        check_row(refresh_row, exp_row, "refresh_row on refresh_cmd");
        exp_row = exp_row + 1'b1;  // Wraps at 2**ROW_W
        ref_count++;
        ref_gap = 0;
        ref_pending = 1'b1;
      end else begin
        ref_gap++;
        if (ref_gap >= MAX_REF_GAP) begin
          $display("No refresh_cmd pulse within %0d cycles", MAX_REF_GAP);
          stop_run();
        end
      end
      if (cpu_ack || bus_ack) begin
        if (cpu_ack) begin
          ack_log.push_back(GNT_CPU);
        end else begin
          ack_log.push_back(GNT_BUS);
        end
        ref_log.push_back(ref_pending);
        ref_pending = 1'b0;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CK);
    $display("The run timed out after %0d cycles", WATCHDOG_CYCLES);
    stop_run();
  end

  initial begin
    arst_n = 1'b0;
    drive_port(GNT_CPU, 1'b0, 1'b0, 1'b0, '0, '0);
    drive_port(GNT_BUS, 1'b0, 1'b0, 1'b0, '0, '0);
    stim[0]  = '{SEL_CPU,  1'b1, 1'b0, 10'h010, 16'h1111};
    stim[1]  = '{SEL_BUS,  1'b1, 1'b0, 10'h011, 16'h2222};
    stim[2]  = '{SEL_CPU,  1'b0, 1'b0, 10'h010, 16'h0000};
    stim[3]  = '{SEL_BUS,  1'b0, 1'b0, 10'h011, 16'h0000};
    stim[4]  = '{SEL_BUS,  1'b0, 1'b0, 10'h010, 16'h0000};  // Cross-port readback
    stim[5]  = '{SEL_CPU,  1'b0, 1'b0, 10'h011, 16'h0000};
    stim[6]  = '{SEL_BOTH, 1'b1, 1'b0, 10'h020, 16'h3c3c};
    stim[7]  = '{SEL_BOTH, 1'b0, 1'b0, 10'h020, 16'h0000};
    stim[8]  = '{SEL_CPU,  1'b1, 1'b0, 10'h3ff, 16'h5a5a};
    stim[9]  = '{SEL_BUS,  1'b0, 1'b0, 10'h3ff, 16'h0000};
    stim[10] = '{SEL_BOTH, 1'b1, 1'b1, 10'h010, 16'h0f0f};  // Semaphore style
    stim[11] = '{SEL_BOTH, 1'b0, 1'b0, 10'h010, 16'h0000};
    stim[12] = '{SEL_BUS,  1'b1, 1'b0, 10'h200, 16'h8001};
    stim[13] = '{SEL_BOTH, 1'b1, 1'b1, 10'h020, 16'hff00};
    stim[14] = '{SEL_BOTH, 1'b0, 1'b0, 10'h020, 16'h0000};
    stim[15] = '{SEL_CPU,  1'b0, 1'b1, 10'h200, 16'h0000};  // Lone lock with nobody waiting
    repeat (5) @(posedge CK);
    #1;
    arst_n = 1'b1;
    for (int pass = 0; pass < NUM_PASSES && ref_count <= 2**ROW_W; pass++) begin
      for (int i = 0; i < TABLE_LEN; i++) begin
        run_entry(stim[i]);
      end
    end
    if (ref_count <= 2**ROW_W) begin
      $display("Only %0d refresh pulses seen, refresh_row never wrapped", ref_count);
      stop_run();
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* list.f */
hw/ram_arb_pkg.sv
hw/wb_port.sv
hw/refresh_timer.sv
hw/ram_arbiter.sv
hw/ram_cycle.sv
hw/ram_subsys_top.sv
testbench/tb_ram_subsys.sv

/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := tb_ram_subsys
FLIST     := list.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FLIST))
PASS_MSG  := Verification passed

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
